// File: design/melee_sprite.mem
// Weapon sprite, one 16-bit opacity mask per row, top row first, MSB is column 0
0003
000e
003c
c0f0
7fc0
3f00
6c00
c600

// File: arena_render.f
design/arena_pkg.sv
design/vga_timing.sv
design/arena_regs.sv
design/boss_draw.sv
design/melee_draw.sv
design/arena_render.sv
tb/arena_render_tb.sv

// File: Makefile
# Verilator build for the arena renderer testbench

TOP := arena_render_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timescale 1ns/1ps --top-module $(TOP) -f arena_render.f

# Pass only when the pass line shows up in the simulator output
run: compile
	./obj_dir/V$(TOP) | awk '{ print } /Regression passed/ { ok = 1 } END { exit !ok }'

clean:
	rm -rf obj_dir

// File: tb/arena_render_tb.sv
// Directed testbench for the arena renderer against a reference pixel model
`default_nettype none
`timescale 1ns/1ps

module arena_render_tb;
    import arena_pkg::*;

    // --------------------
    // Small test frame
    // --------------------
    localparam int H_ACTIVE = 32;
    localparam int H_FRONT  = 2;
    localparam int H_SYNC   = 3;
    localparam int H_BACK   = 3;
    localparam int V_ACTIVE = 24;
    localparam int V_FRONT  = 2;
    localparam int V_SYNC   = 3;
    localparam int V_BACK   = 3;
    localparam int H_TOTAL  = H_ACTIVE + H_FRONT + H_SYNC + H_BACK;
    localparam int V_TOTAL  = V_ACTIVE + V_FRONT + V_SYNC + V_BACK;
    localparam int FRAME_CYCLES   = H_TOTAL * V_TOTAL;
    // About ten frames of tests, plus margin
    localparam int TIMEOUT_CYCLES = 12 * FRAME_CYCLES;

    logic        clk = 1'b0;
    logic        rst;
    wb_req_t     wb_req;
    wb_rsp_t     wb_rsp;
    vga_t        vga_out;

    // Register values the reference model draws with
    arena_ctrl_t         shadow;
    logic [SPRITE_W-1:0] sprite_rows [0:SPRITE_H-1];
    logic [31:0]         lfsr_state  = 32'h4981_382c;
    int                  cycle_count = 0;

    arena_render #(
        .H_ACTIVE (H_ACTIVE),
        .H_FRONT  (H_FRONT),
        .H_SYNC   (H_SYNC),
        .H_BACK   (H_BACK),
        .V_ACTIVE (V_ACTIVE),
        .V_FRONT  (V_FRONT),
        .V_SYNC   (V_SYNC),
        .V_BACK   (V_BACK)
    ) arena_render_inst (
        .clk     (clk),
        .rst     (rst),
        .wb_req  (wb_req),
        .wb_rsp  (wb_rsp),
        .vga_out (vga_out)
    );

    // 100 ns period
    always #50 clk = ~clk;

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("timeout: tests still running after %0d cycles", cycle_count);
            $display("Regression failed");
            $fatal(1, "simulation stopped by the cycle limit");
        end
    end

    // --------------------
    // Helpers
    // --------------------

    // Galois form, taps for x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] state);
        if (state[0]) begin
            return (state >> 1) ^ 32'h8020_0003;
        end
        return state >> 1;
    endfunction

    // One LFSR step per bit taken
    task automatic rand_bits(input int count, output int value);
        int i;
        value = 0;
        for (i = 0; i < count; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            value      = {value[30:0], lfsr_state[0]};
        end
    endtask

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        if (got !== exp) begin
            $display("error: %s is 0x%0h, expected 0x%0h", name, got, exp);
            $display("Regression failed");
            $fatal(1, "first mismatch ends the run");
        end
    endtask

    // Expected colour, boss mark and weapon/boss overlap at one coordinate
    function automatic void ref_pixel(input int h, input int v, output logic [11:0] rgb,
                                      output logic boss, output logic hit);
        int                  box_x;
        int                  col;
        int                  row;
        int                  src_col;
        logic                active;
        logic                on;
        logic [SPRITE_W-1:0] mask;

        active = (h < H_ACTIVE) && (v < V_ACTIVE);
        rgb    = active ? BG_RGB : 12'h000;
        boss   = 1'b0;
        hit    = 1'b0;
        on     = 1'b0;

        // Boss square
        if (active && shadow.game_active && shadow.boss_alive &&
            h >= int'(shadow.boss_x) && h < int'(shadow.boss_x) + BOSS_SIZE &&
            v >= int'(shadow.boss_y) && v < int'(shadow.boss_y) + BOSS_SIZE) begin
            rgb  = BOSS_RGB;
            boss = 1'b1;
        end

        // Sprite box in front of the player, or behind when flipped
        if (shadow.flip) begin
            box_x = int'(shadow.player_x) - MELEE_REACH - SPRITE_W;
        end else begin
            box_x = int'(shadow.player_x) + MELEE_REACH;
        end
        col = h - box_x;
        row = v - int'(shadow.player_y);

        if (active && shadow.attack && shadow.game_active &&
            col >= 0 && col < SPRITE_W && row >= 0 && row < SPRITE_H) begin
            src_col = shadow.flip ? SPRITE_W - 1 - col : col;
            mask    = sprite_rows[3'(row)];
            // Column 0 is the mask MSB
            on      = mask[4'(SPRITE_W - 1 - src_col)];
        end

        // Weapon on top of the boss
        if (on) begin
            rgb = MELEE_RGB;
            hit = boss;
        end
    endfunction

    task automatic check_pixel(input int h, input int v, output logic hit);
        logic [11:0] exp_rgb;
        logic        exp_boss;
        logic        exp_hsync;
        logic        exp_vsync;

        ref_pixel(h, v, exp_rgb, exp_boss, hit);
        exp_hsync = (h >= H_ACTIVE + H_FRONT) && (h < H_ACTIVE + H_FRONT + H_SYNC);
        exp_vsync = (v >= V_ACTIVE + V_FRONT) && (v < V_ACTIVE + V_FRONT + V_SYNC);
        check_value("vga_out.hcount", 64'(vga_out.hcount), 64'(h));
        check_value("vga_out.vcount", 64'(vga_out.vcount), 64'(v));
        check_value("vga_out.hsync", 64'(vga_out.hsync), 64'(exp_hsync));
        check_value("vga_out.vsync", 64'(vga_out.vsync), 64'(exp_vsync));
        check_value("vga_out.hblnk", 64'(vga_out.hblnk), 64'(h >= H_ACTIVE));
        check_value("vga_out.vblnk", 64'(vga_out.vblnk), 64'(v >= V_ACTIVE));
        check_value("vga_out.rgb", 64'(vga_out.rgb), 64'(exp_rgb));
        check_value("vga_out.boss_px", 64'(vga_out.boss_px), 64'(exp_boss));
    endtask

    task automatic wait_pixel(input int h, input int v);
        while (!(int'(vga_out.hcount) == h && int'(vga_out.vcount) == v)) begin
            @(negedge clk);
        end
    endtask

    // Early vertical blanking, with room left for a few bus accesses
    task automatic wait_vblank();
        while (!(int'(vga_out.vcount) >= V_ACTIVE && int'(vga_out.vcount) < V_TOTAL - 2)) begin
            @(negedge clk);
        end
    endtask

    // --------------------
    // Wishbone master
    // --------------------
    task automatic wb_access(input logic write, input logic [1:0] adr,
                             input logic [31:0] wdata, output logic [31:0] rdata);
        int waits;
        @(posedge clk);
        wb_req.cyc   <= 1'b1;
        wb_req.stb   <= 1'b1;
        wb_req.we    <= write;
        wb_req.adr   <= adr;
        wb_req.dat_w <= wdata;
        @(negedge clk);
        waits = 0;
        while (!wb_rsp.ack) begin
            @(negedge clk);
            waits++;
        end
        rdata = wb_rsp.dat_r;
        check_value("wb_rsp.ack delay", 64'(waits), 64'd1);
        // stb is still high through the ack cycle and released on the next edge
        @(posedge clk);
        wb_req.cyc <= 1'b0;
        wb_req.stb <= 1'b0;
        wb_req.we  <= 1'b0;
        @(negedge clk);
        check_value("wb_rsp.ack", 64'(wb_rsp.ack), 64'd0);
    endtask

    task automatic wb_write(input logic [1:0] adr, input logic [31:0] data);
        logic [31:0] unused;
        wb_access(1'b1, adr, data, unused);
    endtask

    task automatic wb_read(input logic [1:0] adr, output logic [31:0] data);
        wb_access(1'b0, adr, 32'd0, data);
    endtask

    // New control and positions during blanking, mirrored into the model
    task automatic configure(input logic [3:0] bits, input int px, input int py,
                             input int bx, input int by);
        wait_vblank();
        wb_write(REG_CTRL, {28'd0, bits});
        wb_write(REG_PLAYER, {4'd0, 12'(py), 4'd0, 12'(px)});
        wb_write(REG_BOSS, {4'd0, 12'(by), 4'd0, 12'(bx)});
        shadow.game_active = bits[0];
        shadow.boss_alive  = bits[1];
        shadow.attack      = bits[2];
        shadow.flip        = bits[3];
        shadow.player_x    = 12'(px);
        shadow.player_y    = 12'(py);
        shadow.boss_x      = 12'(bx);
        shadow.boss_y      = 12'(by);
    endtask

    // Active lines of the next frame, returns at the start of vblank
    task automatic run_frame(output logic any_hit);
        int   h;
        int   v;
        int   i;
        logic hit;
        any_hit = 1'b0;
        h       = 0;
        v       = 0;
        wait_pixel(0, 0);
        for (i = 0; i < V_ACTIVE * H_TOTAL; i++) begin
            check_pixel(h, v, hit);
            if (hit) begin
                any_hit = 1'b1;
            end
            h++;
            if (h == H_TOTAL) begin
                h = 0;
                v++;
            end
            @(negedge clk);
        end
    endtask

    // --------------------
    // Tests
    // --------------------
    task automatic test_reset();
        repeat (3) @(posedge clk);
        @(negedge clk);
        check_value("vga_out", 64'(vga_out), 64'd0);
        check_value("wb_rsp.ack", 64'(wb_rsp.ack), 64'd0);
        check_value("wb_rsp.dat_r", 64'(wb_rsp.dat_r), 64'd0);
        @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
    endtask

    // One full frame from (1,0) through the wrap back to (0,0)
    task automatic test_timing();
        int   h;
        int   v;
        int   i;
        logic hit;
        h = 1;
        v = 0;
        wait_pixel(1, 0);
        for (i = 0; i < FRAME_CYCLES; i++) begin
            check_pixel(h, v, hit);
            h++;
            if (h == H_TOTAL) begin
                h = 0;
                v = (v == V_TOTAL - 1) ? 0 : v + 1;
            end
            @(negedge clk);
        end
    endtask

    task automatic test_registers();
        int          ctrl_val;
        int          px;
        int          py;
        int          bx;
        int          by;
        logic [31:0] rd;
        rand_bits(4, ctrl_val);
        rand_bits(12, px);
        rand_bits(12, py);
        rand_bits(12, bx);
        rand_bits(12, by);
        wb_write(REG_CTRL, 32'(ctrl_val));
        wb_write(REG_PLAYER, {4'd0, 12'(py), 4'd0, 12'(px)});
        wb_write(REG_BOSS, {4'd0, 12'(by), 4'd0, 12'(bx)});
        wb_read(REG_CTRL, rd);
        check_value("REG_CTRL", 64'(rd), 64'(ctrl_val));
        wb_read(REG_PLAYER, rd);
        check_value("REG_PLAYER", 64'(rd), 64'({4'd0, 12'(py), 4'd0, 12'(px)}));
        wb_read(REG_BOSS, rd);
        check_value("REG_BOSS", 64'(rd), 64'({4'd0, 12'(by), 4'd0, 12'(bx)}));
    endtask

    task automatic test_boss();
        int   i;
        int   px;
        int   py;
        int   bx;
        int   by;
        logic any_hit;
        // Attack off, boss at random places
        for (i = 0; i < 2; i++) begin
            rand_bits(5, px);
            rand_bits(5, py);
            rand_bits(5, bx);
            rand_bits(5, by);
            configure(4'b0011, px, py % V_ACTIVE, bx, by % V_ACTIVE);
            run_frame(any_hit);
        end
        // Dead boss, background only
        configure(4'b0001, 4, 4, 8, 8);
        run_frame(any_hit);
    endtask

    task automatic test_weapon();
        int          px;
        int          py;
        int          bx;
        int          by;
        logic        any_hit;
        logic [31:0] rd;
        rand_bits(5, px);
        rand_bits(5, py);
        rand_bits(5, bx);
        rand_bits(5, by);
        configure(4'b0111, px, py % V_ACTIVE, bx, by % V_ACTIVE);
        run_frame(any_hit);
        // Flipped frame starts with a clear hit flag
        wb_write(REG_STATUS, 32'd1);
        // Flipped, boss square right under the whole sprite box
        rand_bits(4, px);
        rand_bits(4, py);
        configure(4'b1111, px + MELEE_REACH + SPRITE_W, py, px, py);
        run_frame(any_hit);
        wb_read(REG_STATUS, rd);
        check_value("REG_STATUS", 64'(rd), 64'(any_hit));
    endtask

    task automatic test_hit();
        logic        any_hit;
        logic [31:0] rd;
        wait_vblank();
        wb_write(REG_STATUS, 32'd1);
        wb_read(REG_STATUS, rd);
        check_value("REG_STATUS", 64'(rd), 64'd0);
        // Sprite box fully inside the boss square
        configure(4'b0111, 4, 6, 12, 6);
        run_frame(any_hit);
        wb_read(REG_STATUS, rd);
        check_value("REG_STATUS", 64'(rd), 64'(any_hit));
        // Writing 0 leaves the flag alone
        wb_write(REG_STATUS, 32'd0);
        wb_read(REG_STATUS, rd);
        check_value("REG_STATUS", 64'(rd), 64'd1);
        wb_write(REG_STATUS, 32'd1);
        wb_read(REG_STATUS, rd);
        check_value("REG_STATUS", 64'(rd), 64'd0);
        // Sprite and boss apart
        configure(4'b0111, 2, 2, 16, 16);
        run_frame(any_hit);
        wb_read(REG_STATUS, rd);
        check_value("REG_STATUS", 64'(rd), 64'(any_hit));
        // Overlapping positions but game inactive
        configure(4'b0110, 4, 6, 12, 6);
        run_frame(any_hit);
        wb_read(REG_STATUS, rd);
        check_value("REG_STATUS", 64'(rd), 64'(any_hit));
    endtask

    initial begin
        rst    = 1'b1;
        wb_req = '0;
        shadow = '0;
        $readmemh("design/melee_sprite.mem", sprite_rows);
        test_reset();
        test_timing();
        test_registers();
        test_boss();
        test_weapon();
        test_hit();
        $display("Regression passed");
        $finish;
    end

endmodule

`default_nettype wire

// File: design/arena_render.sv
// Arena renderer top joining register slave, timing generator and draw stages
`default_nettype none
`timescale 1ns/1ps

module arena_render #(
    parameter int H_ACTIVE = 640,
    parameter int H_FRONT  = 16,
    parameter int H_SYNC   = 96,
    parameter int H_BACK   = 48,
    parameter int V_ACTIVE = 480,
    parameter int V_FRONT  = 10,
    parameter int V_SYNC   = 2,
    parameter int V_BACK   = 33
) (
    input  wire logic               clk,
    input  wire logic               rst,
    input  wire arena_pkg::wb_req_t wb_req,
    output arena_pkg::wb_rsp_t      wb_rsp,
    output arena_pkg::vga_t         vga_out
);
    import arena_pkg::*;

    // --------------------
    // Internal wiring
    // --------------------
    arena_ctrl_t ctrl;
    vga_t        vga_tim;
    vga_t        vga_boss;
    logic        hit_pulse;

    // CPU registers
    arena_regs arena_regs_inst (
        .clk       (clk),
        .rst       (rst),
        .wb_req    (wb_req),
        .wb_rsp    (wb_rsp),
        .hit_pulse (hit_pulse),
        .ctrl      (ctrl)
    );

    // Frame scan, first stage of the stream
    vga_timing #(
        .H_ACTIVE (H_ACTIVE),
        .H_FRONT  (H_FRONT),
        .H_SYNC   (H_SYNC),
        .H_BACK   (H_BACK),
        .V_ACTIVE (V_ACTIVE),
        .V_FRONT  (V_FRONT),
        .V_SYNC   (V_SYNC),
        .V_BACK   (V_BACK)
    ) vga_timing_inst (
        .clk (clk),
        .rst (rst),
        .vga (vga_tim)
    );

    // Boss square, one cycle
    boss_draw boss_draw_inst (
        .clk     (clk),
        .rst     (rst),
        .ctrl    (ctrl),
        .vga_in  (vga_tim),
        .vga_out (vga_boss)
    );

    // Weapon sprite and hit detect, two cycles
    melee_draw melee_draw_inst (
        .clk       (clk),
        .rst       (rst),
        .ctrl      (ctrl),
        .vga_in    (vga_boss),
        .vga_out   (vga_out),
        .hit_pulse (hit_pulse)
    );

endmodule

`default_nettype wire

// File: design/melee_draw.sv
// Melee stage that draws the weapon sprite and flags overlap with the boss
`default_nettype none
`timescale 1ns/1ps

module melee_draw (
    input  wire logic                  clk,
    input  wire logic                  rst,
    input  wire arena_pkg::arena_ctrl_t ctrl,
    input  wire arena_pkg::vga_t       vga_in,
    output arena_pkg::vga_t            vga_out,
    output logic                       hit_pulse
);
    import arena_pkg::*;

    localparam int ROW_W = $clog2(SPRITE_H);
    localparam int COL_W = $clog2(SPRITE_W);

    // Row masks, MSB is the leftmost column
    logic [SPRITE_W-1:0] sprite_rom [0:SPRITE_H-1];

    initial begin
        $readmemh("design/melee_sprite.mem", sprite_rom);
    end

    // Stage 1 signals
    logic [11:0]         box_x;
    logic [11:0]         col;
    logic [11:0]         row;
    logic                in_box;
    logic                draw_nxt;

    // Stage 1 registers
    vga_t                s1;
    logic                draw_q;
    logic                flip_q;
    logic [COL_W-1:0]    col_q;
    logic [SPRITE_W-1:0] mask_q;

    // Stage 2 signals
    logic [COL_W-1:0]    sprite_col;
    logic [COL_W-1:0]    bit_idx;
    logic                pix_on;

    // --------------------
    // Stage 1, box and ROM
    // --------------------

    // Left edge of the sprite box, in front of the player or behind when flipped
    assign box_x = ctrl.flip ? ctrl.player_x - 12'(MELEE_REACH + SPRITE_W)
                             : ctrl.player_x + 12'(MELEE_REACH);

    assign col = vga_in.hcount - box_x;
    assign row = vga_in.vcount - ctrl.player_y;

    // Wrapping subtraction keeps the test to two compares
    assign in_box = (col < 12'(SPRITE_W)) && (row < 12'(SPRITE_H));

    assign draw_nxt = in_box && ctrl.attack && ctrl.game_active &&
                      !vga_in.hblnk && !vga_in.vblnk;

    always_ff @(posedge clk) begin
        if (rst) begin
            s1     <= '0;
            draw_q <= 1'b0;
            flip_q <= 1'b0;
        end else begin
            s1     <= vga_in;
            draw_q <= draw_nxt;
            flip_q <= ctrl.flip;
        end
    end

    // Row read, plain block RAM style
    always_ff @(posedge clk) begin
        mask_q <= sprite_rom[row[ROW_W-1:0]];
        col_q  <= col[COL_W-1:0];
    end

    // --------------------
    // Stage 2, composite
    // --------------------

    // Mirror the column when flipped
    assign sprite_col = flip_q ? COL_W'(SPRITE_W - 1) - col_q : col_q;

    // Column 0 sits at the MSB
    assign bit_idx = COL_W'(SPRITE_W - 1) - sprite_col;
    assign pix_on  = draw_q && mask_q[bit_idx];

    always_ff @(posedge clk) begin
        if (rst) begin
            vga_out   <= '0;
            hit_pulse <= 1'b0;
        end else begin
            vga_out.hcount  <= s1.hcount;
            vga_out.vcount  <= s1.vcount;
            vga_out.hsync   <= s1.hsync;
            vga_out.vsync   <= s1.vsync;
            vga_out.hblnk   <= s1.hblnk;
            vga_out.vblnk   <= s1.vblnk;
            vga_out.boss_px <= s1.boss_px;
            // Weapon sits above the boss
            vga_out.rgb     <= pix_on ? MELEE_RGB : s1.rgb;
            // Overlap with a pixel the boss stage marked
            hit_pulse       <= pix_on && s1.boss_px;
        end
    end

endmodule

`default_nettype wire

// File: design/boss_draw.sv
// Boss stage that paints the boss square and marks its pixels in the stream
`default_nettype none
`timescale 1ns/1ps

module boss_draw (
    input  wire logic                  clk,
    input  wire logic                  rst,
    input  wire arena_pkg::arena_ctrl_t ctrl,
    input  wire arena_pkg::vga_t       vga_in,
    output arena_pkg::vga_t            vga_out
);
    import arena_pkg::*;

    logic [11:0] rel_x;
    logic [11:0] rel_y;
    logic        in_square;
    logic        active;
    logic        draw_boss;

    // --------------------
    // Square test
    // --------------------

    // Offset from the top left corner of the boss
    assign rel_x = vga_in.hcount - ctrl.boss_x;
    assign rel_y = vga_in.vcount - ctrl.boss_y;

    // Unsigned offsets, so anything left or above wraps large
    assign in_square = (rel_x < 12'(BOSS_SIZE)) && (rel_y < 12'(BOSS_SIZE));

    // Never paint into blanking
    assign active = !vga_in.hblnk && !vga_in.vblnk;

    assign draw_boss = in_square && active && ctrl.boss_alive && ctrl.game_active;

    // --------------------
    // Output register
    // --------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            vga_out <= '0;
        end else begin
            vga_out.hcount <= vga_in.hcount;
            vga_out.vcount <= vga_in.vcount;
            vga_out.hsync  <= vga_in.hsync;
            vga_out.vsync  <= vga_in.vsync;
            vga_out.hblnk  <= vga_in.hblnk;
            vga_out.vblnk  <= vga_in.vblnk;
            if (draw_boss) begin
                vga_out.rgb     <= BOSS_RGB;
                vga_out.boss_px <= 1'b1;
            end else begin
                // Pass through whatever came before
                vga_out.rgb     <= vga_in.rgb;
                vga_out.boss_px <= vga_in.boss_px;
            end
        end
    end

endmodule

`default_nettype wire

// File: design/arena_regs.sv
// Wishbone classic register slave for arena control, positions and hit status
`default_nettype none
`timescale 1ns/1ps

module arena_regs (
    input  wire logic              clk,
    input  wire logic              rst,
    input  wire arena_pkg::wb_req_t wb_req,
    output arena_pkg::wb_rsp_t     wb_rsp,
    input  wire logic              hit_pulse,
    output arena_pkg::arena_ctrl_t ctrl
);
    import arena_pkg::*;

    logic        ack_q;
    logic [31:0] dat_q;
    logic        access;
    logic        clr_hit;
    logic [31:0] rd_data;

    // Register storage
    logic [3:0]  ctrl_bits;
    logic [11:0] player_x;
    logic [11:0] player_y;
    logic [11:0] boss_x;
    logic [11:0] boss_y;
    logic        hit_flag;

    // --------------------
    // Bus decode
    // --------------------

    // New request only, a held stb in the ack cycle is ignored
    assign access  = wb_req.cyc && wb_req.stb && !ack_q;
    assign clr_hit = access && wb_req.we && (wb_req.adr == REG_STATUS) && wb_req.dat_w[0];

    // Read mux
    always_comb begin
        case (wb_req.adr)
            REG_CTRL:   rd_data = {28'd0, ctrl_bits};
            REG_PLAYER: rd_data = {4'd0, player_y, 4'd0, player_x};
            REG_BOSS:   rd_data = {4'd0, boss_y, 4'd0, boss_x};
            default:    rd_data = {31'd0, hit_flag};
        endcase
    end

    // --------------------
    // Registers
    // --------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            ack_q     <= 1'b0;
            dat_q     <= '0;
            ctrl_bits <= '0;
            player_x  <= '0;
            player_y  <= '0;
            boss_x    <= '0;
            boss_y    <= '0;
            hit_flag  <= 1'b0;
        end else begin
            ack_q <= access;
            dat_q <= access ? rd_data : 32'd0;
            // Writes land on the same edge that raises ack
            if (access && wb_req.we) begin
                case (wb_req.adr)
                    REG_CTRL: ctrl_bits <= wb_req.dat_w[3:0];
                    REG_PLAYER: begin
                        player_x <= wb_req.dat_w[11:0];
                        player_y <= wb_req.dat_w[27:16];
                    end
                    REG_BOSS: begin
                        boss_x <= wb_req.dat_w[11:0];
                        boss_y <= wb_req.dat_w[27:16];
                    end
                    default: ;
                endcase
            end
            // Sticky hit, a set beats a clear
            hit_flag <= hit_pulse || (hit_flag && !clr_hit);
        end
    end

    // Control view, one cycle behind the registers
    always_ff @(posedge clk) begin
        if (rst) begin
            ctrl <= '0;
        end else begin
            ctrl.game_active <= ctrl_bits[0];
            ctrl.boss_alive  <= ctrl_bits[1];
            ctrl.attack      <= ctrl_bits[2];
            ctrl.flip        <= ctrl_bits[3];
            ctrl.player_x    <= player_x;
            ctrl.player_y    <= player_y;
            ctrl.boss_x      <= boss_x;
            ctrl.boss_y      <= boss_y;
        end
    end

    assign wb_rsp.ack   = ack_q;
    assign wb_rsp.dat_r = dat_q;

endmodule

`default_nettype wire

// File: design/vga_timing.sv
// VGA timing generator producing sync, blanking, coordinates and background
`default_nettype none
`timescale 1ns/1ps

module vga_timing #(
    parameter int H_ACTIVE = 640,
    parameter int H_FRONT  = 16,
    parameter int H_SYNC   = 96,
    parameter int H_BACK   = 48,
    parameter int V_ACTIVE = 480,
    parameter int V_FRONT  = 10,
    parameter int V_SYNC   = 2,
    parameter int V_BACK   = 33
) (
    input  wire logic           clk,
    input  wire logic           rst,
    output arena_pkg::vga_t     vga
);
    import arena_pkg::*;

    // --------------------
    // Frame geometry
    // --------------------
    localparam logic [11:0] H_LAST   = 12'(H_ACTIVE + H_FRONT + H_SYNC + H_BACK - 1);
    localparam logic [11:0] V_LAST   = 12'(V_ACTIVE + V_FRONT + V_SYNC + V_BACK - 1);
    localparam logic [11:0] H_ACT    = 12'(H_ACTIVE);
    localparam logic [11:0] V_ACT    = 12'(V_ACTIVE);
    // Sync windows, start inclusive and end exclusive
    localparam logic [11:0] HS_START = 12'(H_ACTIVE + H_FRONT);
    localparam logic [11:0] HS_END   = 12'(H_ACTIVE + H_FRONT + H_SYNC);
    localparam logic [11:0] VS_START = 12'(V_ACTIVE + V_FRONT);
    localparam logic [11:0] VS_END   = 12'(V_ACTIVE + V_FRONT + V_SYNC);

    logic [11:0] hcnt;
    logic [11:0] vcnt;
    logic        hblnk_nxt;
    logic        vblnk_nxt;

    // --------------------
    // Counters
    // --------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            hcnt <= '0;
            vcnt <= '0;
        end else if (hcnt == H_LAST) begin
            hcnt <= '0;
            // Line done, step or wrap the frame
            vcnt <= (vcnt == V_LAST) ? '0 : vcnt + 12'd1;
        end else begin
            hcnt <= hcnt + 12'd1;
        end
    end

    assign hblnk_nxt = (hcnt >= H_ACT);
    assign vblnk_nxt = (vcnt >= V_ACT);

    // --------------------
    // Registered stream
    // --------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            vga <= '0;
        end else begin
            vga.hcount  <= hcnt;
            vga.vcount  <= vcnt;
            vga.hsync   <= (hcnt >= HS_START) && (hcnt < HS_END);
            vga.vsync   <= (vcnt >= VS_START) && (vcnt < VS_END);
            vga.hblnk   <= hblnk_nxt;
            vga.vblnk   <= vblnk_nxt;
            // Background only inside the active area
            vga.rgb     <= (hblnk_nxt || vblnk_nxt) ? 12'h000 : BG_RGB;
            vga.boss_px <= 1'b0;
        end
    end

endmodule

`default_nettype wire

// File: design/arena_pkg.sv
// Arena package with pixel stream, Wishbone and control types plus game constants
`default_nettype none

package arena_pkg;

    // --------------------
    // Pixel stream
    // --------------------

    // One pixel per clock, all fields delayed together
    typedef struct packed {
        logic [11:0] hcount;
        logic [11:0] vcount;
        logic        hsync;
        logic        vsync;
        logic        hblnk;
        logic        vblnk;
        logic [11:0] rgb;
        logic        boss_px;   // Boss covers this pixel
    } vga_t;

    // --------------------
    // Wishbone classic
    // --------------------

    // Master side, full 32-bit words only
    typedef struct packed {
        logic        cyc;
        logic        stb;
        logic        we;
        logic [1:0]  adr;
        logic [31:0] dat_w;
    } wb_req_t;

    // Slave side
    typedef struct packed {
        logic        ack;
        logic [31:0] dat_r;
    } wb_rsp_t;

    // Register values seen by the draw stages
    typedef struct packed {
        logic        game_active;
        logic        boss_alive;
        logic        attack;
        logic        flip;
        logic [11:0] player_x;
        logic [11:0] player_y;
        logic [11:0] boss_x;
        logic [11:0] boss_y;
    } arena_ctrl_t;

    // Word addresses
    localparam logic [1:0] REG_CTRL   = 2'd0;
    localparam logic [1:0] REG_PLAYER = 2'd1;
    localparam logic [1:0] REG_BOSS   = 2'd2;
    localparam logic [1:0] REG_STATUS = 2'd3;

    // Colours, 4 bits per channel
    localparam logic [11:0] BG_RGB    = 12'h124;
    localparam logic [11:0] BOSS_RGB  = 12'hc22;
    localparam logic [11:0] MELEE_RGB = 12'heea;

    // Object sizes in pixels
    localparam int BOSS_SIZE   = 16;
    localparam int SPRITE_W    = 16;
    localparam int SPRITE_H    = 8;
    localparam int MELEE_REACH = 8;   // Gap between player and sprite

endpackage

`default_nettype wire
